//--- design/rvPkg.sv
package rvPkg;

    localparam int xlen = 32;
    localparam int regAddrWidth = 5;

    typedef logic [xlen-1:0] xlenT;
    typedef logic [31:0] instrT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    // base opcodes of the supported subset
    localparam logic [6:0] opRegReg = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    // addi x0, x0, 0
    localparam instrT nopInstr = 32'h0000_0013;
    localparam xlenT resetPc = 32'h0000_0000;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB
    } aluFuncT;

    typedef enum logic {
        op1Reg,
        op1Pc
    } op1SelT;

    typedef enum logic [2:0] {
        op2Reg,
        op2ImmI,
        op2ImmS,
        op2ImmB,
        op2ImmU,
        op2ImmJ
    } op2SelT;

    // what execute does with the pc
    typedef enum logic [2:0] {
        pcNext,
        pcBeq,
        pcBne,
        pcJump,
        pcJumpReg
    } pcSelT;

    typedef enum logic [1:0] {
        wbAlu,
        wbPc4,
        wbMem
    } wbSelT;

endpackage

//--- design/pipeIf.sv
`timescale 1ns/1ps

// decode to execute
interface decExIf import rvPkg::*; ();
    logic    valid;
    xlenT    pc;
    xlenT    op1;
    xlenT    op2;
    xlenT    storeData;
    aluFuncT aluFunc;
    pcSelT   pcSel;
    wbSelT   wbSel;
    logic    memRead;
    logic    memWrite;
    logic    regWrite;
    regAddrT rd;

    modport src (output valid, pc, op1, op2, storeData, aluFunc, pcSel, wbSel,
                        memRead, memWrite, regWrite, rd);
    modport dst (input  valid, pc, op1, op2, storeData, aluFunc, pcSel, wbSel,
                        memRead, memWrite, regWrite, rd);
endinterface

// execute to memory access
interface exMemIf import rvPkg::*; ();
    logic    valid;
    xlenT    result;
    xlenT    storeData;
    wbSelT   wbSel;
    logic    memRead;
    logic    memWrite;
    logic    regWrite;
    regAddrT rd;

    modport src (output valid, result, storeData, wbSel, memRead, memWrite, regWrite, rd);
    modport dst (input  valid, result, storeData, wbSel, memRead, memWrite, regWrite, rd);
    // hazard view for decode
    modport mon (input  valid, regWrite, rd);
endinterface

// writeback into the register file
interface wbIf import rvPkg::*; ();
    logic    valid;
    logic    regWrite;
    regAddrT rd;
    xlenT    data;

    modport src (output valid, regWrite, rd, data);
    modport dst (input  valid, regWrite, rd, data);
    modport mon (input  valid, regWrite, rd);
endinterface

// pc redirect plus the execute-stage destination for interlock
interface redirectIf import rvPkg::*; ();
    logic    taken;
    xlenT    target;
    logic    valid;
    logic    regWrite;
    regAddrT rd;

    modport src (output taken, target, valid, regWrite, rd);
    modport dst (input  taken, target, valid, regWrite, rd);
endinterface

//--- design/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import rvPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  stall,
    redirectIf.dst redirect,
    output xlenT  pc,
    input  instrT instruction,
    output xlenT  fetchPc,
    output instrT fetchInstr,
    output logic  fetchValid
);

    xlenT pcPlus4;

    assign pcPlus4 = pc + 32'd4;

    // redirect wins over stall for the program counter
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
            fetchValid <= 1'b0;
        end else if (redirect.taken) begin
            pc <= redirect.target;
            fetchValid <= 1'b0;
        end else if (!stall) begin
            pc <= pcPlus4;
            fetchValid <= 1'b1;
        end
    end

    // fetch/decode payload
    always_ff @(posedge clk) begin
        if (redirect.taken) begin
            fetchPc <= pc;
            // squashed slot
            fetchInstr <= nopInstr;
        end else if (!stall) begin
            fetchPc <= pc;
            fetchInstr <= instruction;
        end
    end

endmodule

//--- design/regFile.sv
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT readAddr1,
    input  regAddrT readAddr2,
    output xlenT    readData1,
    output xlenT    readData2,
    wbIf.dst        wb,
    input  regAddrT debugAddr,
    output xlenT    debugData
);

    // x0 is not stored
    xlenT regs [31:1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.regWrite && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // combinational reads without bypass
    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];
    assign debugData = (debugAddr == '0) ? '0 : regs[debugAddr];

endmodule

//--- design/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import rvPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  xlenT    fetchPc,
    input  instrT   fetchInstr,
    input  logic    fetchValid,
    output regAddrT readAddr1,
    output regAddrT readAddr2,
    input  xlenT    readData1,
    input  xlenT    readData2,
    redirectIf.dst  redirect,
    exMemIf.mon     exMem,
    wbIf.mon        wb,
    output logic    stall,
    decExIf.src     decEx
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    regAddrT    rs1;
    regAddrT    rs2;
    regAddrT    rd;
    logic       legal;
    logic       useRs1;
    logic       useRs2;
    logic       rs1Busy;
    logic       rs2Busy;
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       issue;
    aluFuncT    aluFunc;
    op1SelT     op1Sel;
    op2SelT     op2Sel;
    pcSelT      pcSel;
    wbSelT      wbSel;
    xlenT       immI;
    xlenT       immS;
    xlenT       immB;
    xlenT       immU;
    xlenT       immJ;
    xlenT       op1;
    xlenT       op2;

    // true when src waits on a write still in the pipe
    function automatic logic pending(regAddrT src, logic v, logic we, regAddrT dst);
        return v && we && src != '0 && src == dst;
    endfunction

    assign opcode = fetchInstr[6:0];
    assign funct3 = fetchInstr[14:12];
    assign rs1 = fetchInstr[19:15];
    assign rs2 = fetchInstr[24:20];
    assign rd = fetchInstr[11:7];
    assign readAddr1 = rs1;
    assign readAddr2 = rs2;

    assign immI = {{20{fetchInstr[31]}}, fetchInstr[31:20]};
    assign immS = {{20{fetchInstr[31]}}, fetchInstr[31:25], fetchInstr[11:7]};
    assign immB = {{19{fetchInstr[31]}}, fetchInstr[31], fetchInstr[7],
                   fetchInstr[30:25], fetchInstr[11:8], 1'b0};
    assign immU = {fetchInstr[31:12], 12'b0};
    assign immJ = {{11{fetchInstr[31]}}, fetchInstr[31], fetchInstr[19:12],
                   fetchInstr[20], fetchInstr[30:21], 1'b0};

    // control decode
    always_comb begin
        legal = 1'b0;
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        aluFunc = aluAdd;
        op1Sel = op1Reg;
        op2Sel = op2Reg;
        pcSel = pcNext;
        wbSel = wbAlu;
        case (opcode)
            opRegReg: begin
                legal = 1'b1;
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                regWrite = 1'b1;
                case (funct3)
                    3'b000: aluFunc = fetchInstr[30] ? aluSub : aluAdd;
                    3'b010: aluFunc = aluSlt;
                    3'b100: aluFunc = aluXor;
                    3'b110: aluFunc = aluOr;
                    3'b111: aluFunc = aluAnd;
                    default: legal = 1'b0;
                endcase
            end
            opImm: begin
                // addi only
                legal = (funct3 == 3'b000);
                useRs1 = 1'b1;
                regWrite = 1'b1;
                op2Sel = op2ImmI;
            end
            opLui: begin
                legal = 1'b1;
                regWrite = 1'b1;
                op2Sel = op2ImmU;
                aluFunc = aluPassB;
            end
            opLoad: begin
                legal = (funct3 == 3'b010);
                useRs1 = 1'b1;
                regWrite = 1'b1;
                memRead = 1'b1;
                op2Sel = op2ImmI;
                wbSel = wbMem;
            end
            opStore: begin
                legal = (funct3 == 3'b010);
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                memWrite = 1'b1;
                op2Sel = op2ImmS;
            end
            opBranch: begin
                legal = (funct3 == 3'b000) || (funct3 == 3'b001);
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                op2Sel = op2ImmB;
                pcSel = funct3[0] ? pcBne : pcBeq;
            end
            opJal: begin
                legal = 1'b1;
                regWrite = 1'b1;
                op1Sel = op1Pc;
                op2Sel = op2ImmJ;
                pcSel = pcJump;
                wbSel = wbPc4;
            end
            opJalr: begin
                legal = (funct3 == 3'b000);
                useRs1 = 1'b1;
                regWrite = 1'b1;
                op2Sel = op2ImmI;
                pcSel = pcJumpReg;
                wbSel = wbPc4;
            end
            default: legal = 1'b0;
        endcase
    end

    // operand selection
    always_comb begin
        case (op2Sel)
            op2ImmI: op2 = immI;
            op2ImmS: op2 = immS;
            op2ImmB: op2 = immB;
            op2ImmU: op2 = immU;
            op2ImmJ: op2 = immJ;
            default: op2 = readData2;
        endcase
    end

    assign op1 = (op1Sel == op1Pc) ? fetchPc : readData1;

    // interlock against execute, memory and writeback
    assign rs1Busy = pending(rs1, redirect.valid, redirect.regWrite, redirect.rd)
                  || pending(rs1, exMem.valid, exMem.regWrite, exMem.rd)
                  || pending(rs1, wb.valid, wb.regWrite, wb.rd);
    assign rs2Busy = pending(rs2, redirect.valid, redirect.regWrite, redirect.rd)
                  || pending(rs2, exMem.valid, exMem.regWrite, exMem.rd)
                  || pending(rs2, wb.valid, wb.regWrite, wb.rd);
    assign stall = fetchValid && ((useRs1 && rs1Busy) || (useRs2 && rs2Busy));
    assign issue = fetchValid && legal && !stall && !redirect.taken;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decEx.valid <= 1'b0;
            decEx.regWrite <= 1'b0;
            decEx.memRead <= 1'b0;
            decEx.memWrite <= 1'b0;
            decEx.pcSel <= pcNext;
        end else begin
            decEx.valid <= issue;
            decEx.regWrite <= issue && regWrite;
            decEx.memRead <= issue && memRead;
            decEx.memWrite <= issue && memWrite;
            decEx.pcSel <= issue ? pcSel : pcNext;
        end
    end

    always_ff @(posedge clk) begin
        decEx.pc <= fetchPc;
        decEx.op1 <= op1;
        decEx.op2 <= op2;
        decEx.storeData <= readData2;
        decEx.aluFunc <= aluFunc;
        decEx.wbSel <= wbSel;
        decEx.rd <= rd;
    end

endmodule

//--- design/executeStage.sv
`timescale 1ns/1ps

module executeStage import rvPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    decExIf.dst    decEx,
    redirectIf.src redirect,
    exMemIf.src    exMem
);

    xlenT aluResult;
    xlenT jumpRegSum;
    xlenT link;
    logic equal;

    always_comb begin
        case (decEx.aluFunc)
            aluSub:   aluResult = decEx.op1 - decEx.op2;
            aluAnd:   aluResult = decEx.op1 & decEx.op2;
            aluOr:    aluResult = decEx.op1 | decEx.op2;
            aluXor:   aluResult = decEx.op1 ^ decEx.op2;
            aluSlt:   aluResult = {31'b0, $signed(decEx.op1) < $signed(decEx.op2)};
            aluPassB: aluResult = decEx.op2;
            default:  aluResult = decEx.op1 + decEx.op2;
        endcase
    end

    // rs1 against rs2 for beq and bne
    assign equal = (decEx.op1 == decEx.storeData);

    always_comb begin
        case (decEx.pcSel)
            pcBeq:     redirect.taken = decEx.valid && equal;
            pcBne:     redirect.taken = decEx.valid && !equal;
            pcJump,
            pcJumpReg: redirect.taken = decEx.valid;
            default:   redirect.taken = 1'b0;
        endcase
    end

    assign jumpRegSum = decEx.op1 + decEx.op2;
    assign redirect.target = (decEx.pcSel == pcJumpReg) ? {jumpRegSum[31:1], 1'b0}
                                                        : decEx.pc + decEx.op2;

    // destination seen by the decode interlock
    assign redirect.valid = decEx.valid;
    assign redirect.regWrite = decEx.regWrite;
    assign redirect.rd = decEx.rd;

    assign link = decEx.pc + 32'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem.valid <= 1'b0;
            exMem.regWrite <= 1'b0;
            exMem.memRead <= 1'b0;
            exMem.memWrite <= 1'b0;
        end else begin
            exMem.valid <= decEx.valid;
            exMem.regWrite <= decEx.valid && decEx.regWrite;
            exMem.memRead <= decEx.valid && decEx.memRead;
            exMem.memWrite <= decEx.valid && decEx.memWrite;
        end
    end

    always_ff @(posedge clk) begin
        exMem.result <= (decEx.wbSel == wbPc4) ? link : aluResult;
        exMem.storeData <= decEx.storeData;
        exMem.wbSel <= decEx.wbSel;
        exMem.rd <= decEx.rd;
    end

endmodule

//--- design/memWriteback.sv
`timescale 1ns/1ps

module memWriteback import rvPkg::*; (
    input  logic clk,
    input  logic rstN,
    exMemIf.dst  exMem,
    output xlenT memoryAddress,
    output xlenT memoryWriteData,
    output logic memoryReadEnable,
    output logic memoryWriteEnable,
    input  xlenT memoryReadData,
    wbIf.src     wb
);

    // data memory port with enables only for a live item
    assign memoryAddress = exMem.result;
    assign memoryWriteData = exMem.storeData;
    assign memoryReadEnable = exMem.valid && exMem.memRead;
    assign memoryWriteEnable = exMem.valid && exMem.memWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wb.valid <= 1'b0;
            wb.regWrite <= 1'b0;
        end else begin
            wb.valid <= exMem.valid;
            wb.regWrite <= exMem.valid && exMem.regWrite;
        end
    end

    // load data or the execute result
    always_ff @(posedge clk) begin
        wb.data <= (exMem.wbSel == wbMem) ? memoryReadData : exMem.result;
        wb.rd <= exMem.rd;
    end

endmodule

//--- design/rvCore.sv
`timescale 1ns/1ps

module rvCore import rvPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    output xlenT    pc,
    input  instrT   instruction,
    output xlenT    memoryAddress,
    output xlenT    memoryWriteData,
    output logic    memoryReadEnable,
    output logic    memoryWriteEnable,
    input  xlenT    memoryReadData,
    input  regAddrT regFileReadRegisterDebug,
    output xlenT    regFileReadDataDebug
);

    xlenT    fetchPc;
    instrT   fetchInstr;
    logic    fetchValid;
    logic    stall;
    regAddrT readAddr1;
    regAddrT readAddr2;
    xlenT    readData1;
    xlenT    readData2;

    decExIf    decExBus ();
    exMemIf    exMemBus ();
    wbIf       wbBus ();
    redirectIf redirectBus ();

    // input side
    fetchStage i_fetchStage (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .redirect(redirectBus.dst),
        .pc(pc),
        .instruction(instruction),
        .fetchPc(fetchPc),
        .fetchInstr(fetchInstr),
        .fetchValid(fetchValid)
    );

    regFile i_regFile (
        .clk(clk),
        .rstN(rstN),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .readData1(readData1),
        .readData2(readData2),
        .wb(wbBus.dst),
        .debugAddr(regFileReadRegisterDebug),
        .debugData(regFileReadDataDebug)
    );

    decodeStage i_decodeStage (
        .clk(clk),
        .rstN(rstN),
        .fetchPc(fetchPc),
        .fetchInstr(fetchInstr),
        .fetchValid(fetchValid),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .readData1(readData1),
        .readData2(readData2),
        .redirect(redirectBus.dst),
        .exMem(exMemBus.mon),
        .wb(wbBus.mon),
        .stall(stall),
        .decEx(decExBus.src)
    );

    executeStage i_executeStage (
        .clk(clk),
        .rstN(rstN),
        .decEx(decExBus.dst),
        .redirect(redirectBus.src),
        .exMem(exMemBus.src)
    );

    // output side
    memWriteback i_memWriteback (
        .clk(clk),
        .rstN(rstN),
        .exMem(exMemBus.dst),
        .memoryAddress(memoryAddress),
        .memoryWriteData(memoryWriteData),
        .memoryReadEnable(memoryReadEnable),
        .memoryWriteEnable(memoryWriteEnable),
        .memoryReadData(memoryReadData),
        .wb(wbBus.src)
    );

endmodule

//--- sim/tbRvCore.sv
`timescale 1ns/1ps

module tbRvCore import rvPkg::*; ();

    logic    clk;
    logic    rstN;
    xlenT    pc;
    instrT   instruction;
    xlenT    memoryAddress;
    xlenT    memoryWriteData;
    logic    memoryReadEnable;
    logic    memoryWriteEnable;
    xlenT    memoryReadData;
    regAddrT regFileReadRegisterDebug;
    xlenT    regFileReadDataDebug;

    instrT rom [0:255];
    xlenT  ram [0:255];
    xlenT  refMem [0:255];
    xlenT  refRegs [0:31];
    xlenT  expStoreAddr [$];
    xlenT  expStoreData [$];
    xlenT  refLoopPc;
    int    refAccessCount;
    int    accessCount = 0;
    int    storesSeen = 0;
    int    errors = 0;

    rvCore i_rvCore (
        .clk(clk),
        .rstN(rstN),
        .pc(pc),
        .instruction(instruction),
        .memoryAddress(memoryAddress),
        .memoryWriteData(memoryWriteData),
        .memoryReadEnable(memoryReadEnable),
        .memoryWriteEnable(memoryWriteEnable),
        .memoryReadData(memoryReadData),
        .regFileReadRegisterDebug(regFileReadRegisterDebug),
        .regFileReadDataDebug(regFileReadDataDebug)
    );

    always #50 clk = ~clk;

    // rom and ram read combinationally and ram writes at the edge
    assign instruction = rom[pc[9:2]];
    assign memoryReadData = ram[memoryAddress[9:2]];

    always @(posedge clk) begin
        if (memoryWriteEnable) begin
            ram[memoryAddress[9:2]] <= memoryWriteData;
        end
    end

    task automatic checkValue(input xlenT actual, input xlenT expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // scrambled so every address bit matters
    function automatic xlenT fillWord(int idx);
        return (xlenT'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic instrT rType(logic [6:0] f7, regAddrT rs2, regAddrT rs1,
                                    logic [2:0] f3, regAddrT rd);
        return {f7, rs2, rs1, f3, rd, opRegReg};
    endfunction

    function automatic instrT iType(logic [11:0] imm, regAddrT rs1, logic [2:0] f3,
                                    regAddrT rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instrT storeWord(logic [11:0] imm, regAddrT rs2, regAddrT rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic instrT branchWord(logic [12:0] imm, regAddrT rs2, regAddrT rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic instrT luiWord(logic [19:0] imm, regAddrT rd);
        return {imm, rd, opLui};
    endfunction

    function automatic instrT jalWord(logic [20:0] imm, regAddrT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    // fixed template with random immediates, base address and slt operand order
    function automatic void buildProgram();
        logic [19:0] upper;
        logic [11:0] imm1;
        logic [11:0] imm2;
        xlenT        base;
        logic        swapSlt;
        upper = 20'($urandom);
        imm1 = 12'($urandom);
        // nonzero so x2 and x3 always differ
        imm2 = 12'($urandom_range(2047, 1));
        base = 32'd256 + 32'd4 * ($urandom % 128);
        swapSlt = 1'($urandom);
        for (int i = 0; i < 256; i++) begin
            rom[i] = nopInstr;
        end
        rom[0] = luiWord(upper, 1);
        rom[1] = iType(imm1, 0, 3'b000, 2, opImm);
        rom[2] = iType(imm2, 2, 3'b000, 3, opImm);
        rom[3] = rType(7'h00, 3, 1, 3'b000, 4);
        rom[4] = rType(7'h20, 2, 4, 3'b000, 5);
        rom[5] = rType(7'h00, 3, 5, 3'b111, 6);
        rom[6] = rType(7'h00, 1, 6, 3'b110, 7);
        rom[7] = rType(7'h00, 2, 7, 3'b100, 8);
        rom[8] = swapSlt ? rType(7'h00, 2, 3, 3'b010, 9) : rType(7'h00, 3, 2, 3'b010, 9);
        rom[9] = iType(base[11:0], 0, 3'b000, 10, opImm);
        rom[10] = storeWord(12'd0, 4, 10);
        rom[11] = storeWord(12'd4, 8, 10);
        rom[12] = iType(12'd0, 10, 3'b010, 11, opLoad);
        // load followed by its use
        rom[13] = rType(7'h00, 5, 11, 3'b000, 12);
        rom[14] = branchWord(13'd8, 4, 11, 3'b000);
        rom[15] = iType(12'd1, 0, 3'b000, 13, opImm);
        rom[16] = branchWord(13'd8, 4, 11, 3'b001);
        rom[17] = branchWord(13'd8, 3, 2, 3'b000);
        rom[18] = branchWord(13'd8, 3, 2, 3'b001);
        rom[19] = storeWord(12'd12, 1, 10);
        rom[20] = jalWord(21'd8, 15);
        rom[21] = storeWord(12'd12, 1, 10);
        rom[22] = iType(12'd100, 0, 3'b000, 16, opImm);
        rom[23] = iType(12'd0, 16, 3'b000, 17, opJalr);
        rom[24] = iType(12'd3, 0, 3'b000, 18, opImm);
        rom[25] = storeWord(12'd8, 12, 10);
        rom[26] = iType(12'd4, 10, 3'b010, 19, opLoad);
        rom[27] = rType(7'h00, 17, 19, 3'b100, 20);
        rom[28] = jalWord(21'd0, 0);
    endfunction

    // instruction-level model of the program in rom
    function automatic void runReference();
        xlenT    regs [0:31];
        xlenT    curPc;
        xlenT    nextPc;
        xlenT    a;
        xlenT    b;
        xlenT    addr;
        xlenT    immI;
        xlenT    immS;
        xlenT    immB;
        xlenT    immJ;
        instrT   w;
        logic [2:0] f3;
        regAddrT rd;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            refMem[i] = fillWord(i);
        end
        curPc = 32'd0;
        refLoopPc = 32'hffff_ffff;
        refAccessCount = 0;
        for (int step = 0; step < 1000; step++) begin
            w = rom[curPc[9:2]];
            f3 = w[14:12];
            rd = w[11:7];
            a = regs[w[19:15]];
            b = regs[w[24:20]];
            immI = {{20{w[31]}}, w[31:20]};
            immS = {{20{w[31]}}, w[31:25], w[11:7]};
            immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            nextPc = curPc + 32'd4;
            case (w[6:0])
                opRegReg: begin
                    case (f3)
                        3'b000: regs[rd] = w[30] ? a - b : a + b;
                        3'b010: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100: regs[rd] = a ^ b;
                        3'b110: regs[rd] = a | b;
                        default: regs[rd] = a & b;
                    endcase
                end
                opImm: regs[rd] = a + immI;
                opLui: regs[rd] = {w[31:12], 12'b0};
                opLoad: begin
                    addr = a + immI;
                    regs[rd] = refMem[addr[9:2]];
                    refAccessCount++;
                end
                opStore: begin
                    addr = a + immS;
                    refMem[addr[9:2]] = b;
                    expStoreAddr.push_back(addr);
                    expStoreData.push_back(b);
                    refAccessCount++;
                end
                opBranch: begin
                    if ((f3 == 3'b000) == (a == b)) begin
                        nextPc = curPc + immB;
                    end
                end
                opJal: begin
                    regs[rd] = curPc + 32'd4;
                    nextPc = curPc + immJ;
                end
                opJalr: begin
                    regs[rd] = curPc + 32'd4;
                    nextPc = (a + immI) & ~32'd1;
                end
                default: ;
            endcase
            regs[0] = '0;
            if (nextPc == curPc) begin
                refLoopPc = curPc;
                break;
            end
            curPc = nextPc;
        end
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = regs[i];
        end
    endfunction

    // checks stores in program order and counts data-memory accesses
    always @(negedge clk) begin
        xlenT wantAddr;
        xlenT wantData;
        if (memoryReadEnable || memoryWriteEnable) begin
            accessCount++;
        end
        if (memoryWriteEnable) begin
            if (expStoreAddr.size() == 0) begin
                errors++;
                $display("store to %h at %0t was not expected at all", memoryAddress, $time);
            end else begin
                wantAddr = expStoreAddr.pop_front();
                wantData = expStoreData.pop_front();
                checkValue(memoryAddress, wantAddr, "store address");
                checkValue(memoryWriteData, wantData, "store data");
                storesSeen++;
            end
        end
    end

    initial begin
        int   cycle;
        int   loopHits;
        xlenT prevPc;
        clk = 1'b0;
        rstN = 1'b0;
        regFileReadRegisterDebug = '0;
        void'($urandom(32'hf757));
        buildProgram();
        for (int i = 0; i < 256; i++) begin
            ram[i] = fillWord(i);
        end
        runReference();

        for (cycle = 0; cycle < 5; cycle++) begin
            @(posedge clk);
            #1;
            // sweep the debug port once while reset is held
            if (cycle == 2) begin
                for (int r = 0; r < 32; r++) begin
                    regFileReadRegisterDebug = regAddrT'(r);
                    #1;
                    checkValue(regFileReadDataDebug, 32'd0, $sformatf("x%0d in reset", r));
                end
            end
            @(negedge clk);
            checkValue(pc, resetPc, "pc in reset");
            checkValue({31'b0, memoryReadEnable}, 32'd0, "read enable in reset");
            checkValue({31'b0, memoryWriteEnable}, 32'd0, "write enable in reset");
        end
        @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        checkValue(pc, resetPc, "pc after reset");
        checkValue({31'b0, memoryReadEnable}, 32'd0, "read enable after reset");
        checkValue({31'b0, memoryWriteEnable}, 32'd0, "write enable after reset");

        // the self loop refetches its own pc every third cycle
        // only arrivals count so a pc held by a stall counts once
        loopHits = 0;
        prevPc = pc;
        for (cycle = 0; cycle < 2000 && loopHits < 3; cycle++) begin
            @(negedge clk);
            if (pc == refLoopPc && prevPc != refLoopPc) begin
                loopHits++;
            end
            prevPc = pc;
        end

        if (loopHits < 3) begin
            $display("timeout: the core did not reach the final loop in %0d cycles", cycle);
            $display("Test FAILED");
            $finish;
        end else begin
            for (int r = 0; r < 32; r++) begin
                @(posedge clk);
                #1;
                regFileReadRegisterDebug = regAddrT'(r);
                @(negedge clk);
                checkValue(regFileReadDataDebug, refRegs[r], $sformatf("register x%0d", r));
            end
            checkValue(accessCount, refAccessCount, "data memory access count");
            checkValue(expStoreAddr.size(), 32'd0, "stores never seen");
            $display("errors: %0d, stores checked: %0d, memory accesses: %0d",
                     errors, storesSeen, accessCount);
            if (errors == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

//--- verilog.f
design/rvPkg.sv
design/pipeIf.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memWriteback.sv
design/rvCore.sv
sim/tbRvCore.sv
